//--- rtl/thread_mgr_pkg.sv
package thread_mgr_pkg;

  // thread record word widths
  localparam int CTX_W = 32;
  localparam int PC_W  = 32;

  // active table capacity
  localparam int PROC_QUANTITY = 8;
  localparam int IDX_W = 3;
  // count needs one bit more than the index, table can be full
  localparam int CNT_W = 4;

  // result data for accepted commands
  localparam logic [CTX_W-1:0] RUN_ACK_CODE  = 32'hdeadbeef;
  localparam logic [CTX_W-1:0] STOP_ACK_CODE = 32'hbeefdead;

  // one thread, context plus start address
  typedef struct packed {
    logic [CTX_W-1:0] ctx;
    logic [PC_W-1:0]  pc;
  } thread_entry_t;

  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_RUN  = 2'd1,
    CMD_STOP = 2'd2
  } thrd_cmd_e;

  // command result word
  typedef struct packed {
    logic             valid;
    logic             ok;
    logic [CTX_W-1:0] data;
  } cmd_rslt_t;

  // single pending slot
  typedef struct packed {
    logic          valid;
    thread_entry_t entry;
  } pend_t;

  // stop target, start_idx marks where its search round began
  typedef struct packed {
    logic             valid;
    thread_entry_t    entry;
    logic [IDX_W-1:0] start_idx;
  } stop_req_t;

  // dispatched thread
  typedef struct packed {
    logic          valid;
    thread_entry_t entry;
  } disp_t;

endpackage

//--- rtl/thread_cmd_unit.sv
`timescale 1ns/1ps

module thread_cmd_unit (
  input  logic                             clk,
  input  logic                             rst,
  input  thread_mgr_pkg::thrd_cmd_e        cmd_i,
  input  thread_mgr_pkg::thread_entry_t    cmd_entry_i,
  input  logic [thread_mgr_pkg::IDX_W-1:0] cur_idx_i,
  input  logic                             pend_take_i,
  input  logic                             stop_clear_i,
  output thread_mgr_pkg::pend_t            pend_o,
  output thread_mgr_pkg::stop_req_t        stop_o,
  output thread_mgr_pkg::cmd_rslt_t        rslt_o
);
  import thread_mgr_pkg::*;

  pend_t     pend_q;
  stop_req_t stop_q;
  cmd_rslt_t rslt_q;

  // pending slot
  // boot thread (all zero) sits here after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q.valid <= 1'b1;
      pend_q.entry <= '0;
    end else begin
      // take frees the slot from the next cycle on
      if (pend_take_i) begin
        pend_q.valid <= 1'b0;
      end
      // run only lands in an empty slot
      if (cmd_i == CMD_RUN && !pend_q.valid) begin
        pend_q.valid <= 1'b1;
        pend_q.entry <= cmd_entry_i;
      end
    end
  end

  // stop register
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_q.valid <= 1'b0;
    end else begin
      if (stop_clear_i) begin
        stop_q.valid <= 1'b0;
      end
      if (cmd_i == CMD_STOP && !stop_q.valid) begin
        stop_q.valid     <= 1'b1;
        stop_q.entry     <= cmd_entry_i;
        // round of the search starts at the current index
        stop_q.start_idx <= cur_idx_i;
      end
    end
  end

  // result word valid one cycle after any real command
  always_ff @(posedge clk) begin
    if (rst) begin
      rslt_q <= '0;
    end else begin
      rslt_q.valid <= (cmd_i != CMD_NONE);
      // reject by default
      rslt_q.ok    <= 1'b0;
      rslt_q.data  <= '0;
      case (cmd_i)
        CMD_RUN: begin
          if (!pend_q.valid) begin
            rslt_q.ok   <= 1'b1;
            rslt_q.data <= RUN_ACK_CODE;
          end
        end
        CMD_STOP: begin
          if (!stop_q.valid) begin
            rslt_q.ok   <= 1'b1;
            rslt_q.data <= STOP_ACK_CODE;
          end
        end
      endcase
    end
  end

  assign pend_o = pend_q;
  assign stop_o = stop_q;
  assign rslt_o = rslt_q;

endmodule

//--- rtl/thread_table.sv
`timescale 1ns/1ps

module thread_table (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             append_i,
  input  logic                             remove_i,
  input  thread_mgr_pkg::thread_entry_t    wr_entry_i,
  input  logic [thread_mgr_pkg::IDX_W-1:0] rd_idx_i,
  output thread_mgr_pkg::thread_entry_t    rd_entry_o,
  output logic [thread_mgr_pkg::CNT_W-1:0] count_o
);
  import thread_mgr_pkg::*;

  // active threads, always packed into slots 0 .. count-1
  thread_entry_t    mem_q [PROC_QUANTITY];
  thread_entry_t    rd_entry_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] last_cnt;
  logic [IDX_W-1:0] last_idx;
  logic [IDX_W-1:0] wr_idx;

  // slot of the last record, moved into the hole on removal
  assign last_cnt = count_q - 1'b1;
  assign last_idx = last_cnt[IDX_W-1:0];
  // append goes right behind the last record
  assign wr_idx   = count_q[IDX_W-1:0];

  // fill count
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (append_i) begin
      count_q <= count_q + 1'b1;
    end else if (remove_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  // storage and registered read
  always_ff @(posedge clk) begin
    if (append_i) begin
      mem_q[wr_idx] <= wr_entry_i;
    end else if (remove_i) begin
      // compaction by swap, order of the tail is not kept
      mem_q[rd_idx_i] <= mem_q[last_idx];
    end
    // read sees the contents before this edge's write
    rd_entry_q <= mem_q[rd_idx_i];
  end

  assign rd_entry_o = rd_entry_q;
  assign count_o    = count_q;

endmodule

//--- rtl/thread_scheduler.sv
`timescale 1ns/1ps

module thread_scheduler (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             next_thread_i,
  input  thread_mgr_pkg::pend_t            pend_i,
  input  thread_mgr_pkg::stop_req_t        stop_i,
  input  thread_mgr_pkg::thread_entry_t    rd_entry_i,
  input  logic [thread_mgr_pkg::CNT_W-1:0] count_i,
  output logic                             pend_take_o,
  output logic                             stop_clear_o,
  output logic                             append_o,
  output logic                             remove_o,
  output logic [thread_mgr_pkg::IDX_W-1:0] rd_idx_o,
  output logic [thread_mgr_pkg::IDX_W-1:0] cur_idx_o,
  output thread_mgr_pkg::disp_t            disp_o
);
  import thread_mgr_pkg::*;

  // CMP compares the table word read in IDLE
  // REREAD/REDISP fetch the record swapped into the hole
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_CMP    = 2'd1,
    ST_REREAD = 2'd2,
    ST_REDISP = 2'd3
  } state_e;

  state_e           state_q;
  logic             req_q;
  logic [IDX_W-1:0] idx_q;
  disp_t            disp_q;

  logic             take_pend;
  logic             start_read;
  logic             hit;
  logic             give_up;
  logic [CNT_W-1:0] cnt_dec;
  logic [CNT_W-1:0] idx_inc;
  logic [IDX_W-1:0] idx_adv;

  // count after a removal
  assign cnt_dec = count_i - 1'b1;
  // wide increment so index 7 + 1 does not fold back early
  assign idx_inc = CNT_W'(idx_q) + 1'b1;
  // next round-robin index, wraps at count
  assign idx_adv = (idx_inc >= count_i) ? '0 : idx_inc[IDX_W-1:0];

  always_comb begin
    // pending thread wins while the table has room
    take_pend  = (state_q == ST_IDLE) && req_q && pend_i.valid &&
                 (count_i < CNT_W'(PROC_QUANTITY));
    // empty table and nothing pending, request waits
    start_read = (state_q == ST_IDLE) && req_q && !take_pend && (count_i != '0);
    hit        = (state_q == ST_CMP) && stop_i.valid && (rd_entry_i == stop_i.entry);
    // a full round passed without finding the target
    give_up    = (state_q == ST_CMP) && stop_i.valid && !hit &&
                 (idx_adv == stop_i.start_idx);
  end

  assign pend_take_o  = take_pend;
  assign append_o     = take_pend;
  assign remove_o     = hit;
  assign stop_clear_o = hit || give_up;
  assign rd_idx_o     = idx_q;
  assign cur_idx_o    = idx_q;
  assign disp_o       = disp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      req_q        <= 1'b0;
      idx_q        <= '0;
      disp_q.valid <= 1'b0;
    end else begin
      disp_q.valid <= 1'b0;
      // requests during a busy phase fold into one
      if (next_thread_i) begin
        req_q <= 1'b1;
      end else if (take_pend || start_read) begin
        req_q <= 1'b0;
      end

      case (state_q)
        ST_IDLE: begin
          if (take_pend) begin
            // table append happens on this same edge
            disp_q.valid <= 1'b1;
            disp_q.entry <= pend_i.entry;
          end else if (start_read) begin
            state_q <= ST_CMP;
          end
        end

        ST_CMP: begin
          if (hit) begin
            // index past the shrunken table, go back to slot 0
            if (CNT_W'(idx_q) >= cnt_dec) begin
              idx_q <= '0;
            end
            state_q <= ST_REREAD;
          end else begin
            disp_q.valid <= 1'b1;
            disp_q.entry <= rd_entry_i;
            idx_q        <= idx_adv;
            state_q      <= ST_IDLE;
          end
        end

        // table write landed last edge, read launches now
        ST_REREAD: begin
          state_q <= ST_REDISP;
        end

        ST_REDISP: begin
          if (count_i != '0) begin
            disp_q.valid <= 1'b1;
            disp_q.entry <= rd_entry_i;
            idx_q        <= idx_adv;
          end else begin
            // last thread was stopped, keep the request alive
            req_q <= 1'b1;
          end
          state_q <= ST_IDLE;
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/thread_mgr_top.sv
`timescale 1ns/1ps

module thread_mgr_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          next_thread_i,
  input  thread_mgr_pkg::thrd_cmd_e     cmd_i,
  input  thread_mgr_pkg::thread_entry_t cmd_entry_i,
  output thread_mgr_pkg::cmd_rslt_t     rslt_o,
  output thread_mgr_pkg::disp_t         disp_o
);
  import thread_mgr_pkg::*;

  // cmd unit to scheduler
  pend_t            pend;
  stop_req_t        stop;
  // scheduler back to cmd unit
  logic             pend_take;
  logic             stop_clear;
  logic [IDX_W-1:0] cur_idx;
  // scheduler and table
  logic             append;
  logic             remove;
  logic [IDX_W-1:0] rd_idx;
  thread_entry_t    rd_entry;
  logic [CNT_W-1:0] count;

  thread_cmd_unit u_cmd (
    .clk          (clk),
    .rst          (rst),
    .cmd_i        (cmd_i),
    .cmd_entry_i  (cmd_entry_i),
    .cur_idx_i    (cur_idx),
    .pend_take_i  (pend_take),
    .stop_clear_i (stop_clear),
    .pend_o       (pend),
    .stop_o       (stop),
    .rslt_o       (rslt_o)
  );

  // appended record comes straight from the pending slot
  thread_table u_table (
    .clk        (clk),
    .rst        (rst),
    .append_i   (append),
    .remove_i   (remove),
    .wr_entry_i (pend.entry),
    .rd_idx_i   (rd_idx),
    .rd_entry_o (rd_entry),
    .count_o    (count)
  );

  thread_scheduler u_sched (
    .clk           (clk),
    .rst           (rst),
    .next_thread_i (next_thread_i),
    .pend_i        (pend),
    .stop_i        (stop),
    .rd_entry_i    (rd_entry),
    .count_i       (count),
    .pend_take_o   (pend_take),
    .stop_clear_o  (stop_clear),
    .append_o      (append),
    .remove_o      (remove),
    .rd_idx_o      (rd_idx),
    .cur_idx_o     (cur_idx),
    .disp_o        (disp_o)
  );

endmodule

//--- testbench/tb_thread_mgr.sv
`timescale 1ns/1ps

module tb_thread_mgr;
  import thread_mgr_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 50;

  logic          clk;
  logic          rst;
  logic          next_thread_i;
  thrd_cmd_e     cmd_i;
  thread_entry_t cmd_entry_i;
  cmd_rslt_t     rslt_o;
  disp_t         disp_o;

  // pattern reader state
  int            fd;
  int            code;
  int            n_checks;
  string         line;
  logic [7:0]    op;
  logic [31:0]   ctx_v;
  logic [31:0]   pc_v;
  int            ok_v;
  thread_entry_t entry_v;
  cmd_rslt_t     rslt_exp;
  cmd_rslt_t     rslt_got;
  thread_entry_t disp_got;

  thread_mgr_top uut (
    .clk           (clk),
    .rst           (rst),
    .next_thread_i (next_thread_i),
    .cmd_i         (cmd_i),
    .cmd_entry_i   (cmd_entry_i),
    .rslt_o        (rslt_o),
    .disp_o        (disp_o)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "mismatch");
  endtask

  task automatic check_rslt(input cmd_rslt_t got, input cmd_rslt_t exp);
    n_checks++;
    if (got !== exp) begin
      report_mismatch($sformatf("result ok=%0b data=%h, expected ok=%0b data=%h",
                                got.ok, got.data, exp.ok, exp.data));
    end
  endtask

  task automatic check_disp(input thread_entry_t got, input thread_entry_t exp);
    n_checks++;
    if (got !== exp) begin
      report_mismatch($sformatf("dispatch ctx=%h pc=%h, expected ctx=%h pc=%h",
                                got.ctx, got.pc, exp.ctx, exp.pc));
    end
  endtask

  // one-cycle command strobe
  task automatic send_cmd(input thrd_cmd_e cmd, input thread_entry_t entry);
    @(posedge clk);
    cmd_i       <= cmd;
    cmd_entry_i <= entry;
    @(posedge clk);
    cmd_i       <= CMD_NONE;
  endtask

  // one-cycle request pulse
  task automatic pulse_next();
    @(posedge clk);
    next_thread_i <= 1'b1;
    @(posedge clk);
    next_thread_i <= 1'b0;
  endtask

  // outputs sampled on the falling edge, well clear of the update
  task automatic wait_rslt(output cmd_rslt_t got);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (rslt_o.valid) begin
        seen = 1'b1;
        got  = rslt_o;
      end
      cycles++;
    end
    if (!seen) begin
      stop_run("timeout: the command result never became valid");
    end
  endtask

  // dispatch latency varies, valid marks the end
  task automatic wait_disp(output thread_entry_t got);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (disp_o.valid) begin
        seen = 1'b1;
        got  = disp_o.entry;
      end
      cycles++;
    end
    if (!seen) begin
      stop_run("timeout: no thread was dispatched after a next-thread request");
    end
  endtask

  initial begin
    rst           = 1'b1;
    next_thread_i = 1'b0;
    cmd_i         = CMD_NONE;
    cmd_entry_i   = '0;
    n_checks      = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("testbench/thread_mgr_patterns.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the pattern file testbench/thread_mgr_patterns.txt");
    end

    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // skip blank and comment lines
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%c %h %h %d", op, ctx_v, pc_v, ok_v);
        if (code != 4) begin
          stop_run($sformatf("bad pattern line: %s", line));
        end
        entry_v.ctx = ctx_v;
        entry_v.pc  = pc_v;
        if (op == "N") begin
          pulse_next();
          wait_disp(disp_got);
          check_disp(disp_got, entry_v);
        end else if (op == "R" || op == "S") begin
          // expected data follows from the command and its ok bit
          rslt_exp.valid = 1'b1;
          rslt_exp.ok    = (ok_v != 0);
          if (ok_v == 0) begin
            rslt_exp.data = '0;
          end else if (op == "R") begin
            rslt_exp.data = RUN_ACK_CODE;
          end else begin
            rslt_exp.data = STOP_ACK_CODE;
          end
          send_cmd((op == "R") ? CMD_RUN : CMD_STOP, entry_v);
          wait_rslt(rslt_got);
          check_rslt(rslt_got, rslt_exp);
        end else begin
          stop_run($sformatf("unknown operation in pattern line: %s", line));
        end
      end
    end
    $fclose(fd);

    if (n_checks == 0) begin
      $display("no pattern lines were read, nothing was checked");
      $display("SIMULATION FAILED");
      $fatal(1, "empty pattern file");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- thread_mgr.f
rtl/thread_mgr_pkg.sv
rtl/thread_cmd_unit.sv
rtl/thread_table.sv
rtl/thread_scheduler.sv
rtl/thread_mgr_top.sv
testbench/tb_thread_mgr.sv

//--- Bender.yml
package:
  name: thread_mgr

sources:
  # design, package first
  - files:
      - rtl/thread_mgr_pkg.sv
      - rtl/thread_cmd_unit.sv
      - rtl/thread_table.sv
      - rtl/thread_scheduler.sv
      - rtl/thread_mgr_top.sv
  # simulation only
  - target: simulation
    files:
      - testbench/tb_thread_mgr.sv

//--- testbench/thread_mgr_patterns.txt
# columns: op ctx pc ok, op R = run, S = stop, N = next thread request
# on N lines ctx and pc are the expected dispatched thread and ok is unused
N 00000000 00000000 0
R 11111111 a0000001 1
R 22222222 a0000002 0
N 11111111 a0000001 0
R 22222222 a0000002 1
N 22222222 a0000002 0
R 33333333 a0000003 1
N 33333333 a0000003 0
N 00000000 00000000 0
N 11111111 a0000001 0
N 22222222 a0000002 0
N 33333333 a0000003 0
N 00000000 00000000 0
S 22222222 a0000002 1
S 33333333 a0000003 0
N 11111111 a0000001 0
N 33333333 a0000003 0
N 00000000 00000000 0
N 11111111 a0000001 0
N 33333333 a0000003 0
N 00000000 00000000 0
S 99999999 a0000009 1
N 11111111 a0000001 0
N 33333333 a0000003 0
S 88888888 a0000008 0
N 00000000 00000000 0
S 88888888 a0000008 1
N 11111111 a0000001 0
